/* src/rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  // register value, instruction word, register index
  typedef logic [63:0] xlen_t;
  typedef logic [31:0] word_t;
  typedef logic [4:0] reg_addr_t;

  // instruction field widths
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  localparam int num_regs = 32;

  // major opcodes of the integer subset
  localparam opcode_t op_lui    = 7'b0110111;
  localparam opcode_t op_imm    = 7'b0010011;
  localparam opcode_t op_reg    = 7'b0110011;
  localparam opcode_t op_imm_32 = 7'b0011011;
  localparam opcode_t op_reg_32 = 7'b0111011;

  localparam funct3_t f3_add  = 3'b000;
  localparam funct3_t f3_sll  = 3'b001;
  localparam funct3_t f3_slt  = 3'b010;
  localparam funct3_t f3_sltu = 3'b011;
  localparam funct3_t f3_xor  = 3'b100;
  localparam funct3_t f3_sr   = 3'b101;
  localparam funct3_t f3_or   = 3'b110;
  localparam funct3_t f3_and  = 3'b111;

  // sub and sra
  localparam funct7_t funct7_alt = 7'b0100000;

endpackage

`default_nettype wire

/* src/core_ctrl_pkg.sv */
`default_nettype none

package core_ctrl_pkg;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  // where the destination value comes from
  typedef enum logic {
    rd_src_alu,
    rd_src_imm
  } rd_src_e;

  // word results get sign-extended from bit 31
  typedef enum logic {
    rd_ext_dword,
    rd_ext_word
  } rd_ext_e;

  typedef enum logic [1:0] {
    fwd_none,
    fwd_mem,
    fwd_wb
  } fwd_src_e;

endpackage

`default_nettype wire

/* src/inst_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decode import rv_isa_pkg::*, core_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      inst_valid_i,
  input  word_t     inst_i,
  input  logic      wb_wen_i,
  input  reg_addr_t wb_rd_i,
  input  xlen_t     wb_data_i,
  output logic      dec_valid_o,
  output logic      dec_illegal_o,
  output alu_op_e   dec_alu_op_o,
  output logic      dec_word_op_o,
  output logic      dec_use_imm_o,
  output rd_src_e   dec_rd_src_o,
  output rd_ext_e   dec_rd_ext_o,
  output reg_addr_t dec_rd_o,
  output logic      dec_wen_o,
  output reg_addr_t dec_rs1_o,
  output reg_addr_t dec_rs2_o,
  output xlen_t     dec_rs1_data_o,
  output xlen_t     dec_rs2_data_o,
  output xlen_t     dec_imm_o
);

  logic    inst_valid_q;
  word_t   inst_q;
  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;
  funct7_t shift_hi;
  logic    illegal;
  xlen_t   regs [num_regs];

  always_ff @(posedge clk) begin
    if (rst) begin
      inst_valid_q <= 1'b0;
    end else begin
      inst_valid_q <= inst_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_valid_i) begin
      inst_q <= inst_i;
    end
  end

  assign opcode = inst_q[6:0];
  assign funct3 = inst_q[14:12];
  assign funct7 = inst_q[31:25];
  // rv64 immediate shifts carry a 6-bit shamt, so only bits 31:26 qualify
  assign shift_hi = (opcode == op_imm) ? {inst_q[31:26], 1'b0} : funct7;

  always_comb begin
    illegal = 1'b0;
    dec_alu_op_o = alu_add;
    dec_word_op_o = (opcode == op_imm_32) || (opcode == op_reg_32);
    dec_use_imm_o = (opcode == op_imm) || (opcode == op_imm_32);
    dec_rd_src_o = rd_src_alu;
    dec_rd_ext_o = dec_word_op_o ? rd_ext_word : rd_ext_dword;
    dec_imm_o = {{52{inst_q[31]}}, inst_q[31:20]};
    case (opcode)
      op_lui: begin
        dec_rd_src_o = rd_src_imm;
        dec_imm_o = {{32{inst_q[31]}}, inst_q[31:12], 12'b0};
      end
      op_imm, op_reg, op_imm_32, op_reg_32: begin
        case (funct3)
          f3_add: begin
            if (!dec_use_imm_o && funct7 == funct7_alt) begin
              dec_alu_op_o = alu_sub;
            end else if (!dec_use_imm_o && funct7 != '0) begin
              illegal = 1'b1;
            end
          end
          f3_sll: begin
            dec_alu_op_o = alu_sll;
            illegal = (shift_hi != '0);
          end
          f3_sr: begin
            dec_alu_op_o = (shift_hi == funct7_alt) ? alu_sra : alu_srl;
            illegal = (shift_hi != '0) && (shift_hi != funct7_alt);
          end
          default: begin
            case (funct3)
              f3_slt:  dec_alu_op_o = alu_slt;
              f3_sltu: dec_alu_op_o = alu_sltu;
              f3_xor:  dec_alu_op_o = alu_xor;
              f3_or:   dec_alu_op_o = alu_or;
              f3_and:  dec_alu_op_o = alu_and;
              default: dec_alu_op_o = alu_add;
            endcase
            // no word forms of the logic and compare ops
            illegal = dec_word_op_o || (!dec_use_imm_o && funct7 != '0);
          end
        endcase
      end
      default: illegal = 1'b1;
    endcase
  end

  assign dec_valid_o = inst_valid_q;
  assign dec_illegal_o = inst_valid_q && illegal;
  assign dec_rd_o = inst_q[11:7];
  assign dec_rs1_o = inst_q[19:15];
  assign dec_rs2_o = inst_q[24:20];
  assign dec_wen_o = inst_valid_q && !illegal && (dec_rd_o != '0);

  // register file
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_wen_i && wb_rd_i != '0) begin
      regs[wb_rd_i] <= wb_data_i;
    end
  end

  // reads see the value written back this cycle
  assign dec_rs1_data_o = (dec_rs1_o == '0) ? '0 :
                          (wb_wen_i && wb_rd_i == dec_rs1_o) ? wb_data_i : regs[dec_rs1_o];
  assign dec_rs2_data_o = (dec_rs2_o == '0) ? '0 :
                          (wb_wen_i && wb_rd_i == dec_rs2_o) ? wb_data_i : regs[dec_rs2_o];

  // a write to x0 never survives the trip through execute and result
  assert property (@(posedge clk) disable iff (rst) wb_wen_i |-> (wb_rd_i != '0));

endmodule

`default_nettype wire

/* src/int_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module int_execute import rv_isa_pkg::*, core_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      dec_valid_i,
  input  logic      dec_illegal_i,
  input  alu_op_e   dec_alu_op_i,
  input  logic      dec_word_op_i,
  input  logic      dec_use_imm_i,
  input  rd_src_e   dec_rd_src_i,
  input  rd_ext_e   dec_rd_ext_i,
  input  reg_addr_t dec_rd_i,
  input  logic      dec_wen_i,
  input  reg_addr_t dec_rs1_i,
  input  reg_addr_t dec_rs2_i,
  input  xlen_t     dec_rs1_data_i,
  input  xlen_t     dec_rs2_data_i,
  input  xlen_t     dec_imm_i,
  input  logic      mem_wen_i,
  input  reg_addr_t mem_rd_i,
  input  xlen_t     mem_data_i,
  input  logic      wb_wen_i,
  input  reg_addr_t wb_rd_i,
  input  xlen_t     wb_data_i,
  output logic      ex_valid_o,
  output logic      ex_illegal_o,
  output xlen_t     ex_result_o,
  output xlen_t     ex_imm_o,
  output reg_addr_t ex_rd_o,
  output logic      ex_wen_o,
  output rd_src_e   ex_rd_src_o,
  output rd_ext_e   ex_rd_ext_o
);

  alu_op_e    alu_op_q;
  logic       word_op_q;
  logic       use_imm_q;
  reg_addr_t  rs1_q;
  reg_addr_t  rs2_q;
  xlen_t      rs1_data_q;
  xlen_t      rs2_data_q;
  fwd_src_e   fwd1;
  fwd_src_e   fwd2;
  xlen_t      op_a;
  xlen_t      op_b;
  logic [5:0] shamt;

  // newest producer wins: memory slot, then write-back
  function automatic fwd_src_e fwd_select(input reg_addr_t rs, input logic m_wen,
                                          input reg_addr_t m_rd, input logic w_wen,
                                          input reg_addr_t w_rd);
    fwd_src_e sel;
    if (rs == '0) begin
      sel = fwd_none;
    end else if (m_wen && m_rd == rs) begin
      sel = fwd_mem;
    end else if (w_wen && w_rd == rs) begin
      sel = fwd_wb;
    end else begin
      sel = fwd_none;
    end
    return sel;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid_o <= 1'b0;
      ex_illegal_o <= 1'b0;
      ex_wen_o <= 1'b0;
    end else begin
      ex_valid_o <= dec_valid_i;
      ex_illegal_o <= dec_illegal_i;
      ex_wen_o <= dec_wen_i;
    end
  end

  always_ff @(posedge clk) begin
    alu_op_q <= dec_alu_op_i;
    word_op_q <= dec_word_op_i;
    use_imm_q <= dec_use_imm_i;
    ex_rd_src_o <= dec_rd_src_i;
    ex_rd_ext_o <= dec_rd_ext_i;
    ex_rd_o <= dec_rd_i;
    rs1_q <= dec_rs1_i;
    rs2_q <= dec_rs2_i;
    rs1_data_q <= dec_rs1_data_i;
    rs2_data_q <= dec_rs2_data_i;
    ex_imm_o <= dec_imm_i;
  end

  assign fwd1 = fwd_select(rs1_q, mem_wen_i, mem_rd_i, wb_wen_i, wb_rd_i);
  assign fwd2 = fwd_select(rs2_q, mem_wen_i, mem_rd_i, wb_wen_i, wb_rd_i);

  // word ops only use the low half; sra needs the sign above bit 31
  assign op_a = (fwd1 == fwd_mem) ? mem_data_i : (fwd1 == fwd_wb) ? wb_data_i : rs1_data_q;
  assign op_b = use_imm_q ? ex_imm_o :
                (fwd2 == fwd_mem) ? mem_data_i : (fwd2 == fwd_wb) ? wb_data_i : rs2_data_q;
  assign shamt = word_op_q ? {1'b0, op_b[4:0]} : op_b[5:0];

  always_comb begin
    xlen_t a;
    a = word_op_q ? {{32{alu_op_q == alu_sra && op_a[31]}}, op_a[31:0]} : op_a;
    case (alu_op_q)
      alu_add:  ex_result_o = a + op_b;
      alu_sub:  ex_result_o = a - op_b;
      alu_sll:  ex_result_o = a << shamt;
      alu_slt:  ex_result_o = {63'b0, $signed(a) < $signed(op_b)};
      alu_sltu: ex_result_o = {63'b0, a < op_b};
      alu_xor:  ex_result_o = a ^ op_b;
      alu_srl:  ex_result_o = a >> shamt;
      alu_sra:  ex_result_o = $signed(a) >>> shamt;
      alu_or:   ex_result_o = a | op_b;
      alu_and:  ex_result_o = a & op_b;
      default:  ex_result_o = '0;
    endcase
  end

  // the memory slot never offers x0 as a forwarding source
  assert property (@(posedge clk) disable iff (rst) mem_wen_i |-> (mem_rd_i != '0));

endmodule

`default_nettype wire

/* src/result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module result_stage import rv_isa_pkg::*, core_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      ex_valid_i,
  input  logic      ex_illegal_i,
  input  xlen_t     ex_result_i,
  input  xlen_t     ex_imm_i,
  input  reg_addr_t ex_rd_i,
  input  logic      ex_wen_i,
  input  rd_src_e   ex_rd_src_i,
  input  rd_ext_e   ex_rd_ext_i,
  output logic      mem_wen_o,
  output reg_addr_t mem_rd_o,
  output xlen_t     mem_data_o,
  output logic      wb_wen_o,
  output reg_addr_t wb_rd_o,
  output xlen_t     wb_data_o,
  output logic      retire_valid_o,
  output logic      retire_illegal_o,
  output reg_addr_t retire_rd_o,
  output xlen_t     retire_data_o
);

  logic    mem_valid_q;
  logic    mem_illegal_q;
  xlen_t   mem_result_q;
  xlen_t   mem_imm_q;
  rd_src_e mem_rd_src_q;
  rd_ext_e mem_rd_ext_q;
  xlen_t   mem_raw;
  logic    wb_valid_q;
  logic    wb_illegal_q;

  // memory slot
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_valid_q <= 1'b0;
      mem_illegal_q <= 1'b0;
      mem_wen_o <= 1'b0;
    end else begin
      mem_valid_q <= ex_valid_i;
      mem_illegal_q <= ex_illegal_i;
      mem_wen_o <= ex_wen_i;
    end
  end

  always_ff @(posedge clk) begin
    mem_result_q <= ex_result_i;
    mem_imm_q <= ex_imm_i;
    mem_rd_o <= ex_rd_i;
    mem_rd_src_q <= ex_rd_src_i;
    mem_rd_ext_q <= ex_rd_ext_i;
  end

  assign mem_raw = (mem_rd_src_q == rd_src_imm) ? mem_imm_q : mem_result_q;
  assign mem_data_o = (mem_rd_ext_q == rd_ext_word) ? {{32{mem_raw[31]}}, mem_raw[31:0]}
                                                    : mem_raw;

  // write-back
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid_q <= 1'b0;
      wb_illegal_q <= 1'b0;
      wb_wen_o <= 1'b0;
    end else begin
      wb_valid_q <= mem_valid_q;
      wb_illegal_q <= mem_illegal_q;
      wb_wen_o <= mem_wen_o;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd_o <= mem_rd_o;
    wb_data_o <= mem_data_o;
  end

  assign retire_valid_o = wb_valid_q;
  assign retire_illegal_o = wb_illegal_q;
  assign retire_rd_o = wb_rd_o;
  assign retire_data_o = wb_data_o;

  assert property (@(posedge clk) disable iff (rst) !$isunknown(retire_valid_o));

endmodule

`default_nettype wire

/* src/int_pipe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module int_pipe_top import rv_isa_pkg::*, core_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      inst_valid_i,
  input  word_t     inst_i,
  output logic      retire_valid_o,
  output logic      retire_illegal_o,
  output reg_addr_t retire_rd_o,
  output xlen_t     retire_data_o
);

  logic      dec_valid;
  logic      dec_illegal;
  alu_op_e   dec_alu_op;
  logic      dec_word_op;
  logic      dec_use_imm;
  rd_src_e   dec_rd_src;
  rd_ext_e   dec_rd_ext;
  reg_addr_t dec_rd;
  logic      dec_wen;
  reg_addr_t dec_rs1;
  reg_addr_t dec_rs2;
  xlen_t     dec_rs1_data;
  xlen_t     dec_rs2_data;
  xlen_t     dec_imm;
  logic      ex_valid;
  logic      ex_illegal;
  xlen_t     ex_result;
  xlen_t     ex_imm;
  reg_addr_t ex_rd;
  logic      ex_wen;
  rd_src_e   ex_rd_src;
  rd_ext_e   ex_rd_ext;
  logic      mem_wen;
  reg_addr_t mem_rd;
  xlen_t     mem_data;
  logic      wb_wen;
  reg_addr_t wb_rd;
  xlen_t     wb_data;

  inst_decode inst_decode_inst (
    .clk(clk), .rst(rst), .inst_valid_i(inst_valid_i), .inst_i(inst_i),
    .wb_wen_i(wb_wen), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
    .dec_valid_o(dec_valid), .dec_illegal_o(dec_illegal), .dec_alu_op_o(dec_alu_op),
    .dec_word_op_o(dec_word_op), .dec_use_imm_o(dec_use_imm), .dec_rd_src_o(dec_rd_src),
    .dec_rd_ext_o(dec_rd_ext), .dec_rd_o(dec_rd), .dec_wen_o(dec_wen),
    .dec_rs1_o(dec_rs1), .dec_rs2_o(dec_rs2), .dec_rs1_data_o(dec_rs1_data),
    .dec_rs2_data_o(dec_rs2_data), .dec_imm_o(dec_imm)
  );

  int_execute int_execute_inst (
    .clk(clk), .rst(rst), .dec_valid_i(dec_valid), .dec_illegal_i(dec_illegal),
    .dec_alu_op_i(dec_alu_op), .dec_word_op_i(dec_word_op), .dec_use_imm_i(dec_use_imm),
    .dec_rd_src_i(dec_rd_src), .dec_rd_ext_i(dec_rd_ext), .dec_rd_i(dec_rd),
    .dec_wen_i(dec_wen), .dec_rs1_i(dec_rs1), .dec_rs2_i(dec_rs2),
    .dec_rs1_data_i(dec_rs1_data), .dec_rs2_data_i(dec_rs2_data), .dec_imm_i(dec_imm),
    .mem_wen_i(mem_wen), .mem_rd_i(mem_rd), .mem_data_i(mem_data),
    .wb_wen_i(wb_wen), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
    .ex_valid_o(ex_valid), .ex_illegal_o(ex_illegal), .ex_result_o(ex_result),
    .ex_imm_o(ex_imm), .ex_rd_o(ex_rd), .ex_wen_o(ex_wen),
    .ex_rd_src_o(ex_rd_src), .ex_rd_ext_o(ex_rd_ext)
  );

  result_stage result_stage_inst (
    .clk(clk), .rst(rst), .ex_valid_i(ex_valid), .ex_illegal_i(ex_illegal),
    .ex_result_i(ex_result), .ex_imm_i(ex_imm), .ex_rd_i(ex_rd), .ex_wen_i(ex_wen),
    .ex_rd_src_i(ex_rd_src), .ex_rd_ext_i(ex_rd_ext),
    .mem_wen_o(mem_wen), .mem_rd_o(mem_rd), .mem_data_o(mem_data),
    .wb_wen_o(wb_wen), .wb_rd_o(wb_rd), .wb_data_o(wb_data),
    .retire_valid_o(retire_valid_o), .retire_illegal_o(retire_illegal_o),
    .retire_rd_o(retire_rd_o), .retire_data_o(retire_data_o)
  );

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // high over two rising edges, released on a falling edge
  initial begin
    rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

/* verification/tb_int_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_int_pipe import rv_isa_pkg::*; ();

  localparam int n_idle = 5;
  localparam int n_random = 150;
  localparam int chain_len = 12;
  localparam int n_word = 100;
  localparam int n_illegal = 80;
  localparam int n_gap = 100;
  localparam int drain_slack = 8;
  // chains idle d-1 cycles per step for d = 1..4, gap stream strobes half the time
  localparam int est_cycles = n_idle + n_random + chain_len * 10 + n_word + n_illegal
                              + 2 * n_gap + 6 * drain_slack;
  localparam int timeout_cycles = 3 * est_cycles;

  typedef struct packed {
    logic [31:0] due;
    logic        illegal;
    reg_addr_t   rd;
    xlen_t       data;
  } retire_t;

  logic      clk;
  logic      rst;
  logic      inst_valid;
  word_t     inst_word;
  logic      retire_valid;
  logic      retire_illegal;
  reg_addr_t retire_rd;
  xlen_t     retire_data;

  xlen_t       model_regs [num_regs] = '{default: '0};
  retire_t     exp_q [$];
  int unsigned cycle = 0;
  int          errors = 0;
  int          checks = 0;
  int          tests_failed = 0;

  tb_clock_gen tb_clock_gen_inst (
    .clk_o(clk),
    .rst_o(rst)
  );

  int_pipe_top int_pipe_top_inst (
    .clk(clk), .rst(rst), .inst_valid_i(inst_valid), .inst_i(inst_word),
    .retire_valid_o(retire_valid), .retire_illegal_o(retire_illegal),
    .retire_rd_o(retire_rd), .retire_data_o(retire_data)
  );

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= timeout_cycles) begin
      $display("timeout: run went past %0d cycles", timeout_cycles);
      $display("Something failed");
      $finish;
    end
  end

  function automatic xlen_t sext32(input logic [31:0] w);
    return {{32{w[31]}}, w};
  endfunction

  // funct7 / funct6 field rules of the supported subset
  function automatic logic legal_high_bits(input word_t w);
    logic [6:0] f7;
    logic       sft;
    f7 = w[31:25];
    sft = (w[14:12] == f3_sll) || (w[14:12] == f3_sr);
    if ((w[6:0] == op_imm || w[6:0] == op_imm_32) && !sft) begin
      return 1'b1;
    end
    // rv64 OP-IMM shifts take a 6-bit shamt
    if (w[6:0] == op_imm) begin
      f7[0] = 1'b0;
    end
    if (f7 == 7'd0) begin
      return 1'b1;
    end
    return (f7 == funct7_alt) && (w[14:12] == f3_sr || w[14:12] == f3_add);
  endfunction

  // reference model, evaluated in program order
  function automatic void evaluate(input word_t w, output logic illegal, output xlen_t value);
    xlen_t       a;
    xlen_t       b;
    logic [31:0] a32;
    logic [31:0] b32;
    logic        alt;
    a = model_regs[w[19:15]];
    if (w[6:0] == op_reg || w[6:0] == op_reg_32) begin
      b = model_regs[w[24:20]];
    end else begin
      b = {{52{w[31]}}, w[31:20]};
    end
    a32 = a[31:0];
    b32 = b[31:0];
    alt = (w[31:25] == funct7_alt);
    illegal = 1'b0;
    value = '0;
    case (w[6:0])
      op_lui: value = sext32({w[31:12], 12'h000});
      op_imm, op_reg: begin
        case (w[14:12])
          f3_add:  value = (w[6:0] == op_reg && alt) ? a - b : a + b;
          f3_sll:  value = a << b[5:0];
          f3_slt:  value = {63'd0, $signed(a) < $signed(b)};
          f3_sltu: value = {63'd0, a < b};
          f3_xor:  value = a ^ b;
          f3_sr:   value = w[30] ? xlen_t'($signed(a) >>> b[5:0]) : a >> b[5:0];
          f3_or:   value = a | b;
          default: value = a & b;
        endcase
        illegal = !legal_high_bits(w);
      end
      op_imm_32, op_reg_32: begin
        case (w[14:12])
          f3_add:  value = sext32((w[6:0] == op_reg_32 && alt) ? a32 - b32 : a32 + b32);
          f3_sll:  value = sext32(a32 << b32[4:0]);
          f3_sr:   value = sext32(w[30] ? 32'($signed(a32) >>> b32[4:0]) : a32 >> b32[4:0]);
          default: illegal = 1'b1;
        endcase
        if (!legal_high_bits(w)) begin
          illegal = 1'b1;
        end
      end
      default: illegal = 1'b1;
    endcase
  endfunction

  // legal OP or OP-IMM, any rd/rs including x0
  function automatic word_t gen_alu64();
    word_t      r;
    word_t      s;
    funct3_t    f3;
    logic [11:0] imm;
    r = $urandom();
    s = $urandom();
    f3 = r[14:12];
    if (s[0]) begin
      return {((f3 == f3_add || f3 == f3_sr) && s[1]) ? funct7_alt : 7'd0,
              r[24:20], r[19:15], f3, r[11:7], op_reg};
    end
    imm = r[31:20];
    if (f3 == f3_sll) begin
      imm = {6'd0, r[25:20]};
    end else if (f3 == f3_sr) begin
      imm = {s[1] ? 6'b010000 : 6'd0, r[25:20]};
    end
    return {imm, r[19:15], f3, r[11:7], op_imm};
  endfunction

  // LUI or a legal W-type instruction
  function automatic word_t gen_word();
    word_t   r;
    word_t   s;
    funct3_t f3;
    funct7_t f7;
    r = $urandom();
    s = $urandom();
    if (s[1:0] == 2'd0) begin
      return {r[31:12], r[11:7], op_lui};
    end
    f3 = (s[4:3] == 2'd1) ? f3_sll : (s[4:3] == 2'd2) ? f3_sr : f3_add;
    f7 = (f3 != f3_sll && s[5]) ? funct7_alt : 7'd0;
    if (s[2]) begin
      return {f7, r[24:20], r[19:15], f3, r[11:7], op_reg_32};
    end
    if (f3 == f3_add) begin
      return {r[31:20], r[19:15], f3, r[11:7], op_imm_32};
    end
    return {(f3 == f3_sr) ? f7 : 7'd0, r[24:20], r[19:15], f3, r[11:7], op_imm_32};
  endfunction

  function automatic word_t gen_unsupported();
    word_t      r;
    logic [6:0] opc;
    r = $urandom();
    opc = r[6:0];
    while (opc == op_lui || opc == op_imm || opc == op_reg || opc == op_imm_32 ||
           opc == op_reg_32) begin
      r = $urandom();
      opc = r[6:0];
    end
    return r;
  endfunction

  task automatic check_retire();
    retire_t e;
    while (exp_q.size() > 0 && exp_q[0].due < cycle) begin
      e = exp_q.pop_front();
      $display("missing retire for rd x%0d, it was due in cycle %0d", e.rd, e.due);
      errors++;
    end
    if (exp_q.size() > 0 && exp_q[0].due == cycle) begin
      e = exp_q.pop_front();
      checks++;
      if (retire_valid !== 1'b1) begin
        $display("no retire at %0t, one was expected for rd x%0d", $time, e.rd);
        errors++;
      end else begin
        if (retire_illegal !== e.illegal) begin
          $display("Mismatch at %0t: retire_illegal_o expected %b, got %b",
                   $time, e.illegal, retire_illegal);
          errors++;
        end
        if (retire_rd !== e.rd) begin
          $display("Mismatch at %0t: retire_rd_o expected %0d, got %0d", $time, e.rd, retire_rd);
          errors++;
        end
        // illegal instructions carry no meaningful data
        if (!e.illegal && retire_data !== e.data) begin
          $display("Mismatch at %0t: retire_data_o expected %h, got %h",
                   $time, e.data, retire_data);
          errors++;
        end
      end
    end else if (retire_valid !== 1'b0) begin
      $display("retire at %0t without a matching issue", $time);
      errors++;
    end
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    check_retire();
    inst_valid = 1'b0;
    inst_word = $urandom();
  endtask

  task automatic issue(input word_t w);
    logic    illegal;
    xlen_t   value;
    retire_t e;
    @(negedge clk);
    check_retire();
    evaluate(w, illegal, value);
    if (!illegal && w[11:7] != 5'd0) begin
      model_regs[w[11:7]] = value;
    end
    // sampled on the next edge, retired 3 edges later
    e.due = cycle + 4;
    e.illegal = illegal;
    e.rd = w[11:7];
    e.data = value;
    exp_q.push_back(e);
    inst_valid = 1'b1;
    inst_word = w;
  endtask

  task automatic end_test(input int num, input string name, input int err_before);
    while (exp_q.size() > 0) begin
      idle_cycle();
    end
    if (errors == err_before) begin
      $display("test %0d %s: pass", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", num, name, errors - err_before);
    end
  endtask

  initial begin
    word_t     w;
    word_t     r;
    reg_addr_t chain_rd;
    reg_addr_t bad_rd;
    int        err0;
    int        issued;
    inst_valid = 1'b0;
    inst_word = '0;
    void'($urandom(57));
    @(negedge rst);

    err0 = errors;
    repeat (n_idle) idle_cycle();
    end_test(1, "idle after reset", err0);

    err0 = errors;
    repeat (n_random) issue(gen_alu64());
    end_test(2, "random alu", err0);

    // distance 1 mem forward, 2 wb forward, 3 regfile bypass, 4 regfile
    err0 = errors;
    r = $urandom();
    chain_rd = (r[4:0] == 5'd0) ? 5'd5 : r[4:0];
    for (int d = 1; d <= 4; d++) begin
      repeat (chain_len) begin
        w = gen_alu64();
        r = $urandom();
        w[11:7] = chain_rd;
        w[19:15] = chain_rd;
        if (w[6:0] == op_reg && r[0]) begin
          w[24:20] = chain_rd;
        end
        issue(w);
        repeat (d - 1) idle_cycle();
      end
    end
    end_test(3, "dependent chains", err0);

    err0 = errors;
    for (int i = 0; i < 8; i++) begin
      r = $urandom();
      // large positive values so word sums wrap past bit 31
      issue({4'h7, r[15:0], 5'(8 + i), op_lui});
    end
    repeat (n_word - 8) begin
      w = gen_word();
      r = $urandom();
      if (w[6:0] != op_lui) begin
        w[19:15] = {2'b01, r[2:0]};
      end
      if (w[6:0] == op_reg_32) begin
        w[24:20] = {2'b01, r[5:3]};
      end
      issue(w);
    end
    end_test(4, "word ops and lui", err0);

    err0 = errors;
    issued = 0;
    while (issued < n_illegal) begin
      r = $urandom();
      if (r[1:0] == 2'd0) begin
        w = gen_unsupported();
        bad_rd = w[11:7];
        issue(w);
        // read back the rd that the illegal one must leave alone
        issue({12'h000, bad_rd, f3_add, r[11:7], op_imm});
        issued += 2;
      end else begin
        issue(r[2] ? gen_alu64() : gen_word());
        issued++;
      end
    end
    end_test(5, "unsupported opcodes", err0);

    err0 = errors;
    issued = 0;
    while (issued < n_gap) begin
      r = $urandom();
      if (r[0]) begin
        issue(r[1] ? gen_alu64() : (r[2] ? gen_word() : gen_unsupported()));
        issued++;
      end else begin
        idle_cycle();
      end
    end
    end_test(6, "stream with gaps", err0);

    $display("6 tests, %0d failed, %0d retires checked, %0d errors",
             tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
src/rv_isa_pkg.sv
src/core_ctrl_pkg.sv
src/inst_decode.sv
src/int_execute.sv
src/result_stage.sv
src/int_pipe_top.sv
verification/tb_clock_gen.sv
verification/tb_int_pipe.sv

/* run_sim.sh */
#!/bin/sh
# build and run the int_pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --assert -Wno-fatal --top-module tb_int_pipe \
    -f filelist.f -Mdir obj_dir -o tb_int_pipe_sim; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_int_pipe_sim > "$log" 2>&1
status=$?
cat "$log"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Everything OK" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1
